/* filelist.f */
verilog/iigs_mem_pkg.sv
verilog/mem_bank.sv
verilog/slot_regs.sv
verilog/bank_router.sv
verilog/slow_ram_arbiter.sv
verilog/video_fetcher.sv
verilog/iigs_mem_top.sv
tb/iigs_mem_asserts.sv
tb/tb_iigs_mem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile with Verilator and run the IIGS memory testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_iigs_mem -f filelist.f -o sim_iigs_mem

# a failing assertion may stop the run early, the grep below decides
out=$(./obj_dir/sim_iigs_mem || true)
echo "$out"

if grep -q "TESTBENCH PASSED" <<< "$out"; then
  exit 0
else
  exit 1
fi

/* tb/tb_iigs_mem.sv */
`timescale 1ns/10ps

module tb_iigs_mem;

  import iigs_mem_pkg::*;

  localparam int          FAST_BANK_BITS = 2;
  localparam int          VID_INTERVAL   = 4;
  localparam logic [16:0] VID_BASE       = 17'h1_2000;
  localparam int          VID_LEN        = 64;
  localparam logic [16:0] VID_LAST       = 17'(VID_BASE + VID_LEN - 1);
  localparam int          WAIT_LIMIT     = 20;

  logic       clk_sys;
  logic       rst;
  logic       cpu_req;
  bus_req_t   cpu_bus;
  logic [7:0] shadow;
  logic       slot7_ext;
  logic       rsp_valid;
  bus_rsp_t   rsp;
  logic       vid_enable;
  logic       vid_valid;
  vid_byte_t  vid_out;

  // reference model, fast and slow keyed by their RAM byte address
  logic [7:0] fast_model [int];
  logic [7:0] slow_model [int];
  logic [7:0] slot_model [16];

  integer      seed;
  int          errors;
  int          checks;
  int          tests;
  int          err_mark;
  int          chk_mark;
  int          vid_count;
  int          vid_start;
  logic [16:0] vid_expect;

  // scratch for the stimulus loops
  logic [7:0]  bank;
  logic [15:0] addr;
  logic [7:0]  data;
  logic [23:0] loc;
  int          pos;
  logic [23:0] addr_q [$];

  iigs_mem_top #(
    .FAST_BANK_BITS(FAST_BANK_BITS),
    .VID_INTERVAL(VID_INTERVAL),
    .VID_BASE(VID_BASE),
    .VID_LEN(VID_LEN)
  ) iigs_mem_top_inst (
    .clk_sys(clk_sys), .rst(rst), .cpu_req(cpu_req), .cpu_bus(cpu_bus),
    .shadow(shadow), .slot7_ext(slot7_ext), .rsp_valid(rsp_valid), .rsp(rsp),
    .vid_enable(vid_enable), .vid_valid(vid_valid), .vid_out(vid_out)
  );

  // 8 ns clock
  initial clk_sys = 1'b0;
  always #4 clk_sys = ~clk_sys;

  function automatic int rand_below(int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  // one of the four banks that see shadowing or the I/O page
  function automatic logic [7:0] pick_io_bank();
    logic [7:0] b;
    b = (rand_below(2) == 1) ? 8'hE0 : 8'h00;
    return b | 8'(rand_below(2));
  endfunction

  // random address inside the text, HGR1, HGR2 or I/O window
  function automatic logic [15:0] window_addr(int sel);
    case (sel)
      0:       return TEXT_LO + 16'(rand_below(16'h0400));
      1:       return HGR1_LO + 16'(rand_below(16'h2000));
      2:       return HGR2_LO + 16'(rand_below(16'h2000));
      default: return IO_LO + 16'(rand_below(16'h4000));
    endcase
  endfunction

  // region of an access, straight from the decode priority list
  function automatic region_e model_region(logic [7:0] b, logic [15:0] a,
                                           logic [7:0] sh, logic ext);
    logic low_bank;
    logic e_bank;
    logic page_ok;
    low_bank = (b == 8'h00) || (b == 8'h01);
    e_bank   = (b == 8'hE0) || (b == 8'hE1);
    // in bank 01 the display pages also need shadow bit 4 low
    page_ok  = (b == 8'h00) || !sh[4];
    if ((low_bank || e_bank) && ext && a >= SLOT_BASE && a <= SLOT_LAST)
      return REG_SLOT;
    if (e_bank)
      return REG_SLOW;
    if (low_bank)
    begin
      // shadow bits are inhibits, a cleared bit means the page is shadowed
      if (a >= IO_LO && sh[6])
        return REG_SLOW;
      if (page_ok && a >= TEXT_LO && a <= TEXT_HI && !sh[0])
        return REG_SLOW;
      if (page_ok && a >= HGR1_LO && a <= HGR1_HI && !sh[1])
        return REG_SLOW;
      if (page_ok && a >= HGR2_LO && a <= HGR2_HI && !sh[2])
        return REG_SLOW;
    end
    if (int'(b) < (1 << FAST_BANK_BITS))
      return REG_FAST;
    return REG_NONE;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    checks++;
    assert (exp == got)
    else
    begin
      $display("error %s exp %h got %h", name, exp, got);
      errors++;
    end
  endtask

  // soft switches change on a clock edge, between accesses
  task automatic set_switches(input logic [7:0] sh, input logic ext);
    @(posedge clk_sys);
    shadow    <= sh;
    slot7_ext <= ext;
  endtask

  // one strobed CPU access, lat counts cycles from the strobe to rsp_valid
  task automatic bus_access(input logic [7:0] b, input logic [15:0] a,
                            input logic we, input logic [7:0] wdata,
                            output logic [7:0] rdata, output int lat);
    bus_req_t req;
    int       cycles;
    req.bank  = b;
    req.addr  = a;
    req.wdata = wdata;
    req.we    = we;
    @(posedge clk_sys);
    cpu_req <= 1'b1;
    cpu_bus <= req;
    @(posedge clk_sys);
    cpu_req <= 1'b0;
    cycles = 0;
    lat    = 0;
    rdata  = 8'h00;
    // sample on the falling edge where rsp is settled
    while (lat == 0 && cycles < WAIT_LIMIT)
    begin
      @(negedge clk_sys);
      cycles++;
      if (rsp_valid)
      begin
        lat   = cycles;
        rdata = rsp.rdata;
      end
    end
    if (lat == 0)
    begin
      $display("timeout, no rsp_valid for bank %h addr %h", b, a);
      errors++;
    end
  endtask

  // runs an access and keeps the model in step with it
  task automatic checked_access(input logic [7:0] b, input logic [15:0] a,
                                input logic we, input logic [7:0] wdata,
                                input int max_lat);
    logic [7:0] got;
    int         lat;
    region_e    exp_region;
    int         key;
    logic       known;
    logic [7:0] exp;
    bus_access(b, a, we, wdata, got, lat);
    // shadow and slot7_ext are steady across the access
    exp_region = model_region(b, a, shadow, slot7_ext);
    known = 1'b0;
    exp   = 8'h00;
    if (lat != 0)
    begin
      checks++;
      assert (lat <= max_lat)
      else
      begin
        $display("response took %0d cycles, limit is %0d", lat, max_lat);
        errors++;
      end
    end
    case (exp_region)
      REG_FAST:
      begin
        key = int'({b[FAST_BANK_BITS-1:0], a});
        if (we)
          fast_model[key] = wdata;
        else if (fast_model.exists(key))
        begin
          known = 1'b1;
          exp   = fast_model[key];
        end
      end
      REG_SLOW:
      begin
        key = int'({b[0], a});
        if (we)
          slow_model[key] = wdata;
        else if (slow_model.exists(key))
        begin
          known = 1'b1;
          exp   = slow_model[key];
        end
      end
      REG_SLOT:
      begin
        if (we)
          slot_model[a[3:0]] = wdata;
        else
        begin
          known = 1'b1;
          exp   = slot_model[a[3:0]];
        end
      end
      default:
      begin
        known = !we;
        exp   = 8'h80;
      end
    endcase
    if (known && lat != 0)
      check_value("rsp.rdata", exp, got);
  endtask

  task automatic wait_video_byte();
    int start;
    int cycles;
    start  = vid_count;
    cycles = 0;
    while (vid_count == start && cycles < WAIT_LIMIT)
    begin
      @(posedge clk_sys);
      cycles++;
    end
    if (vid_count == start)
    begin
      $display("timeout, no video byte arrived");
      errors++;
    end
  endtask

  task automatic start_test();
    err_mark = errors;
    chk_mark = checks;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %s, %0d checks, %0d errors", tests, name,
             (errors == err_mark) ? "ok" : "mismatch", checks - chk_mark,
             errors - err_mark);
  endtask

  // every fetched byte must be the next window address and hold the model data
  always @(negedge clk_sys)
  begin
    if (!rst && vid_valid)
    begin
      check_value("vid_out.addr", 32'(vid_expect), 32'(vid_out.addr));
      if (slow_model.exists(int'(vid_out.addr)))
        check_value("vid_out.data", 32'(slow_model[int'(vid_out.addr)]), 32'(vid_out.data));
      else
      begin
        $display("video byte from an address the model never wrote");
        errors++;
      end
      if (vid_expect == VID_LAST)
        vid_expect = VID_BASE;
      else
        vid_expect = vid_expect + 17'd1;
      vid_count++;
    end
  end

  initial
  begin
    seed       = 32'h06d7_03a3;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    vid_count  = 0;
    vid_expect = VID_BASE;
    rst        = 1'b1;
    cpu_req    = 1'b0;
    cpu_bus    = '0;
    shadow     = 8'hFF;
    slot7_ext  = 1'b0;
    vid_enable = 1'b0;
    // the slot registers come out of reset cleared
    for (int i = 0; i < 16; i++)
      slot_model[i] = 8'h00;
    repeat (10) @(posedge clk_sys);
    rst <= 1'b0;

    // fast RAM with every shadow inhibited, reads come back in random order
    start_test();
    set_switches(8'hBF, 1'b0);
    for (int i = 0; i < 40; i++)
    begin
      bank = 8'(rand_below(4));
      addr = 16'(rand_below(65536));
      addr_q.push_back({bank, addr});
      checked_access(bank, addr, 1'b1, 8'(rand_below(256)), 1);
    end
    while (addr_q.size() > 0)
    begin
      pos = rand_below(addr_q.size());
      loc = addr_q[pos];
      addr_q.delete(pos);
      checked_access(loc[23:16], loc[15:0], 1'b0, 8'h00, 1);
    end
    end_test("fast ram");

    // the E0/E1 alias always reaches slow RAM, so it shows where a write went
    start_test();
    for (int i = 0; i < 64; i++)
    begin
      if (i % 8 == 0)
        set_switches(8'(rand_below(256)), 1'b0);
      bank = pick_io_bank();
      addr = window_addr(rand_below(4));
      data = 8'(rand_below(256));
      checked_access(bank, addr, 1'b1, data, 1);
      checked_access(bank, addr, 1'b0, 8'h00, 1);
      checked_access(8'hE0 | {7'd0, bank[0]}, addr, 1'b0, 8'h00, 1);
    end
    end_test("shadow decode");

    // unmapped banks, then the slot window with the card on and off
    start_test();
    set_switches(8'hBF, 1'b0);
    for (int i = 0; i < 20; i++)
    begin
      bank = 8'h04 + 8'(rand_below(8'hDC));
      if (rand_below(4) == 0)
        bank = 8'hE2 + 8'(rand_below(30));
      checked_access(bank, 16'(rand_below(65536)), 1'b0, 8'h00, 1);
    end
    set_switches(8'(rand_below(256)), 1'b1);
    for (int i = 0; i < 16; i++)
      checked_access(pick_io_bank(), SLOT_BASE + 16'(i), 1'b1, 8'(rand_below(256)), 1);
    for (int i = 0; i < 24; i++)
      checked_access(pick_io_bank(), SLOT_BASE + 16'(rand_below(16)), 1'b0, 8'h00, 1);
    set_switches(8'(rand_below(256)), 1'b0);
    for (int i = 0; i < 16; i++)
    begin
      bank = pick_io_bank();
      addr = SLOT_BASE + 16'(rand_below(16));
      checked_access(bank, addr, 1'b1, 8'(rand_below(256)), 1);
      checked_access(bank, addr, 1'b0, 8'h00, 1);
      checked_access(8'hE0 | {7'd0, bank[0]}, addr, 1'b0, 8'h00, 1);
    end
    // writes that fell through must have left the device registers alone
    set_switches(shadow, 1'b1);
    for (int i = 0; i < 16; i++)
      checked_access(8'hE1, SLOT_BASE + 16'(i), 1'b0, 8'h00, 1);
    end_test("unmapped and slot");

    // fill the display window, then let the fetcher wrap around it twice
    start_test();
    set_switches(8'hBF, 1'b0);
    for (int i = 0; i < VID_LEN; i++)
    begin
      addr = VID_BASE[15:0] + 16'(i);
      checked_access(8'hE0 | {7'd0, VID_BASE[16]}, addr, 1'b1, 8'(rand_below(256)), 1);
    end
    vid_expect = VID_BASE;
    @(posedge clk_sys);
    vid_enable <= 1'b1;
    for (int i = 0; i < 2 * VID_LEN + 4; i++)
      wait_video_byte();
    end_test("video fetch");

    // slow RAM traffic outside the window while video keeps its priority
    start_test();
    vid_start = vid_count;
    for (int i = 0; i < 40; i++)
    begin
      if (rand_below(2) == 1)
      begin
        bank = 8'hE1;
        addr = 16'h6000 + 16'(rand_below(16'h8000));
      end
      else
      begin
        bank = 8'hE0;
        addr = 16'(rand_below(65536));
      end
      // idle gaps move the CPU strobe against the fetch period
      repeat (rand_below(4)) @(posedge clk_sys);
      checked_access(bank, addr, 1'b1, 8'(rand_below(256)), 2);
      checked_access(bank, addr, 1'b0, 8'h00, 2);
    end
    checks++;
    assert (vid_count > vid_start)
    else
    begin
      $display("no video bytes arrived during CPU traffic");
      errors++;
    end
    @(posedge clk_sys);
    vid_enable <= 1'b0;
    repeat (4) @(posedge clk_sys);
    end_test("contention");

    if (iigs_mem_top_inst.iigs_mem_asserts_inst.fail_count != 0)
    begin
      $display("%0d protocol assertion failures in the bound checker",
               iigs_mem_top_inst.iigs_mem_asserts_inst.fail_count);
      errors += iigs_mem_top_inst.iigs_mem_asserts_inst.fail_count;
    end

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* tb/iigs_mem_asserts.sv */
`timescale 1ns/10ps

module iigs_mem_asserts (
  input logic clk_sys,
  input logic rst,
  input logic cpu_req,
  input logic rsp_valid,
  input logic vid_req,
  input logic vid_valid,
  input logic slow_done,
  input logic vid_done
);

  // set by a CPU strobe, cleared by its response
  logic outstanding;

  // number of assertion failures seen so far
  int fail_count = 0;

  always_ff @(posedge clk_sys)
  begin
    if (rst)
      outstanding <= 1'b0;
    else if (cpu_req)
      outstanding <= 1'b1;
    else if (rsp_valid)
      outstanding <= 1'b0;
  end

  rsp_needs_req: assert property (@(posedge clk_sys) disable iff (rst)
    rsp_valid |-> outstanding)
    else
    begin
      $error("rsp_valid with no CPU access outstanding");
      fail_count++;
    end

  // video always wins the slow RAM, so its byte is back one cycle later
  vid_one_cycle: assert property (@(posedge clk_sys) disable iff (rst)
    vid_req |=> vid_valid)
    else
    begin
      $error("vid_valid did not follow vid_req by one cycle");
      fail_count++;
    end

  vid_from_req: assert property (@(posedge clk_sys) disable iff (rst)
    vid_valid |-> $past(vid_req))
    else
    begin
      $error("vid_valid without a vid_req the cycle before");
      fail_count++;
    end

  one_owner: assert property (@(posedge clk_sys) disable iff (rst)
    !(slow_done && vid_done))
    else
    begin
      $error("both arbiter done strobes high together");
      fail_count++;
    end

  quiet_in_reset: assert property (@(posedge clk_sys)
    rst |=> (!rsp_valid && !vid_valid && !vid_req && !slow_done))
    else
    begin
      $error("strobe active while in reset");
      fail_count++;
    end

endmodule

bind iigs_mem_top iigs_mem_asserts iigs_mem_asserts_inst (
  .clk_sys(clk_sys), .rst(rst), .cpu_req(cpu_req), .rsp_valid(rsp_valid),
  .vid_req(vid_req), .vid_valid(vid_valid), .slow_done(slow_done),
  .vid_done(vid_done)
);

/* verilog/iigs_mem_top.sv */
`timescale 1ns/10ps

module iigs_mem_top #(
  parameter int          FAST_BANK_BITS = 2,
  parameter int          VID_INTERVAL   = 4,
  parameter logic [16:0] VID_BASE       = 17'h1_2000,
  parameter int          VID_LEN        = 64
) (
  input  logic                    clk_sys,
  input  logic                    rst,
  input  logic                    cpu_req,
  input  iigs_mem_pkg::bus_req_t  cpu_bus,
  input  logic [7:0]              shadow,
  input  logic                    slot7_ext,
  output logic                    rsp_valid,
  output iigs_mem_pkg::bus_rsp_t  rsp,
  input  logic                    vid_enable,
  output logic                    vid_valid,
  output iigs_mem_pkg::vid_byte_t vid_out
);

  import iigs_mem_pkg::*;

  // fast RAM side
  logic                        fast_en;
  logic                        fast_we;
  logic [16+FAST_BANK_BITS-1:0] fast_addr;
  logic [7:0]                  fast_wdata;
  logic [7:0]                  fast_rdata;

  // slot 7 registers
  logic       slot_sel;
  logic       slot_we;
  logic [3:0] slot_idx;
  logic [7:0] slot_wdata;
  logic [7:0] slot_rdata;

  // slow RAM, shared between the router and the video fetcher
  logic        slow_req;
  ram_req_t    slow_bus;
  logic        slow_done;
  logic [7:0]  slow_rdata;
  logic        vid_req;
  logic [16:0] vid_addr;
  logic        vid_done;
  logic        ram_en;
  logic        ram_we;
  logic [16:0] ram_addr;
  logic [7:0]  ram_wdata;

  bank_router #(
    .FAST_BANK_BITS(FAST_BANK_BITS)
  ) bank_router_inst (
    .clk_sys(clk_sys), .rst(rst), .cpu_req(cpu_req), .cpu_bus(cpu_bus),
    .shadow(shadow), .slot7_ext(slot7_ext), .rsp_valid(rsp_valid), .rsp(rsp),
    .fast_en(fast_en), .fast_we(fast_we), .fast_addr(fast_addr),
    .fast_wdata(fast_wdata), .fast_rdata(fast_rdata),
    .slot_sel(slot_sel), .slot_we(slot_we), .slot_idx(slot_idx),
    .slot_wdata(slot_wdata), .slot_rdata(slot_rdata),
    .slow_req(slow_req), .slow_bus(slow_bus), .slow_done(slow_done),
    .slow_rdata(slow_rdata)
  );

  mem_bank #(.ADDR_BITS(16 + FAST_BANK_BITS)) fast_ram (
    .clk_sys(clk_sys), .en(fast_en), .we(fast_we), .addr(fast_addr),
    .wdata(fast_wdata), .rdata(fast_rdata)
  );

  slot_regs slot_regs_inst (
    .clk_sys(clk_sys), .rst(rst), .sel(slot_sel), .we(slot_we),
    .idx(slot_idx), .wdata(slot_wdata), .rdata(slot_rdata)
  );

  slow_ram_arbiter slow_ram_arbiter_inst (
    .clk_sys(clk_sys), .rst(rst), .cpu_req(slow_req), .cpu_bus(slow_bus),
    .cpu_done(slow_done), .vid_req(vid_req), .vid_addr(vid_addr),
    .vid_done(vid_done), .ram_en(ram_en), .ram_we(ram_we),
    .ram_addr(ram_addr), .ram_wdata(ram_wdata)
  );

  // both readers take the registered slow RAM output directly
  mem_bank #(.ADDR_BITS(17)) slow_ram (
    .clk_sys(clk_sys), .en(ram_en), .we(ram_we), .addr(ram_addr),
    .wdata(ram_wdata), .rdata(slow_rdata)
  );

  video_fetcher #(
    .VID_INTERVAL(VID_INTERVAL),
    .VID_BASE(VID_BASE),
    .VID_LEN(VID_LEN)
  ) video_fetcher_inst (
    .clk_sys(clk_sys), .rst(rst), .vid_enable(vid_enable),
    .vid_req(vid_req), .vid_addr(vid_addr), .vid_done(vid_done),
    .ram_rdata(slow_rdata), .vid_valid(vid_valid), .vid_out(vid_out)
  );

endmodule

/* verilog/video_fetcher.sv */
`timescale 1ns/10ps

module video_fetcher #(
  parameter int          VID_INTERVAL = 4,
  parameter logic [16:0] VID_BASE     = 17'h1_2000,
  parameter int          VID_LEN      = 64
) (
  input  logic                    clk_sys,
  input  logic                    rst,
  input  logic                    vid_enable,
  output logic                    vid_req,
  output logic [16:0]             vid_addr,
  input  logic                    vid_done,
  input  logic [7:0]              ram_rdata,
  output logic                    vid_valid,
  output iigs_mem_pkg::vid_byte_t vid_out
);

  localparam int          CNT_W    = $clog2(VID_INTERVAL);
  localparam logic [16:0] VID_LAST = 17'(VID_BASE + VID_LEN - 1);

  logic [CNT_W-1:0] cnt;
  logic [16:0]      ptr;
  logic [16:0]      last_addr;

  // interval counter, the strobe fires VID_INTERVAL cycles after enable
  // and the pointer restarts at the window base whenever video is off
  always_ff @(posedge clk_sys)
  begin
    if (rst || !vid_enable)
    begin
      cnt     <= '0;
      ptr     <= VID_BASE;
      vid_req <= 1'b0;
    end
    else
    begin
      vid_req <= (cnt == CNT_W'(VID_INTERVAL - 1));
      cnt     <= (cnt == CNT_W'(VID_INTERVAL - 1)) ? '0 : cnt + 1'b1;
      if (vid_req)
        ptr <= (ptr == VID_LAST) ? VID_BASE : ptr + 17'd1;
    end
  end

  // keep the issued address so it survives a pointer reset in flight
  always_ff @(posedge clk_sys)
  begin
    if (vid_req)
      last_addr <= ptr;
  end

  assign vid_addr = ptr;

  // slow RAM data is already registered, deliver it on the done strobe
  assign vid_valid     = vid_done;
  assign vid_out.addr  = last_addr;
  assign vid_out.data  = ram_rdata;

endmodule

/* verilog/slow_ram_arbiter.sv */
`timescale 1ns/10ps

module slow_ram_arbiter (
  input  logic                   clk_sys,
  input  logic                   rst,
  input  logic                   cpu_req,
  input  iigs_mem_pkg::ram_req_t cpu_bus,
  output logic                   cpu_done,
  input  logic                   vid_req,
  input  logic [16:0]            vid_addr,
  output logic                   vid_done,
  output logic                   ram_en,
  output logic                   ram_we,
  output logic [16:0]            ram_addr,
  output logic [7:0]             ram_wdata
);

  import iigs_mem_pkg::*;

  logic     pend;
  ram_req_t pend_bus;
  ram_req_t cpu_src;
  logic     grant_vid;
  logic     grant_cpu;

  // video always wins, the CPU takes the port on any free cycle
  assign grant_vid = vid_req;
  assign grant_cpu = !vid_req && (pend || cpu_req);

  // a request that lost last cycle is served from the holding register
  assign cpu_src = pend ? pend_bus : cpu_bus;

  // video only ever reads
  assign ram_en    = grant_vid || grant_cpu;
  assign ram_we    = grant_cpu && cpu_src.we;
  assign ram_addr  = grant_vid ? vid_addr : cpu_src.addr;
  assign ram_wdata = cpu_src.wdata;

  // done strobes line up with the registered RAM output
  always_ff @(posedge clk_sys)
  begin
    if (rst)
    begin
      pend     <= 1'b0;
      cpu_done <= 1'b0;
      vid_done <= 1'b0;
    end
    else
    begin
      cpu_done <= grant_cpu;
      vid_done <= grant_vid;
      if (cpu_req && vid_req)
        pend <= 1'b1;
      else if (grant_cpu)
        pend <= 1'b0;
    end
  end

  // one slot is enough since the CPU keeps a single access outstanding
  always_ff @(posedge clk_sys)
  begin
    if (cpu_req)
      pend_bus <= cpu_bus;
  end

endmodule

/* verilog/bank_router.sv */
`timescale 1ns/10ps

module bank_router #(
  parameter int FAST_BANK_BITS = 2
) (
  input  logic                        clk_sys,
  input  logic                        rst,
  input  logic                        cpu_req,
  input  iigs_mem_pkg::bus_req_t      cpu_bus,
  input  logic [7:0]                  shadow,
  input  logic                        slot7_ext,
  output logic                        rsp_valid,
  output iigs_mem_pkg::bus_rsp_t      rsp,
  output logic                        fast_en,
  output logic                        fast_we,
  output logic [16+FAST_BANK_BITS-1:0] fast_addr,
  output logic [7:0]                  fast_wdata,
  input  logic [7:0]                  fast_rdata,
  output logic                        slot_sel,
  output logic                        slot_we,
  output logic [3:0]                  slot_idx,
  output logic [7:0]                  slot_wdata,
  input  logic [7:0]                  slot_rdata,
  output logic                        slow_req,
  output iigs_mem_pkg::ram_req_t      slow_bus,
  input  logic                        slow_done,
  input  logic [7:0]                  slow_rdata
);

  import iigs_mem_pkg::*;

  localparam int FAST_BANKS = 1 << FAST_BANK_BITS;

  logic    bank_lo;
  logic    bank_io;
  logic    aux_ok;
  logic    shadow_hit;
  region_e region;
  region_e region_q;
  logic    busy;

  // banks 00/01 are the shadowed ones, E0/E1 also see the I/O page
  assign bank_lo = (cpu_bus.bank == 8'h00) || (cpu_bus.bank == 8'h01);
  assign bank_io = bank_lo || (cpu_bus.bank == 8'hE0) || (cpu_bus.bank == 8'hE1);

  // bank 01 display pages only shadow when the aux inhibit bit is low
  assign aux_ok = (cpu_bus.bank == 8'h00) || !shadow[4];

  // shadow bits are inhibits, so a cleared bit sends the page to slow RAM
  assign shadow_hit = bank_lo && (
    ((cpu_bus.addr >= IO_LO) && shadow[6]) ||
    ((cpu_bus.addr >= TEXT_LO) && (cpu_bus.addr <= TEXT_HI) && !shadow[0] && aux_ok) ||
    ((cpu_bus.addr >= HGR1_LO) && (cpu_bus.addr <= HGR1_HI) && !shadow[1] && aux_ok) ||
    ((cpu_bus.addr >= HGR2_LO) && (cpu_bus.addr <= HGR2_HI) && !shadow[2] && aux_ok));

  // decode in priority order, slot window first
  always_comb
  begin
    if (bank_io && slot7_ext && (cpu_bus.addr >= SLOT_BASE) && (cpu_bus.addr <= SLOT_LAST))
      region = REG_SLOT;
    else if ((cpu_bus.bank == 8'hE0) || (cpu_bus.bank == 8'hE1) || shadow_hit)
      region = REG_SLOW;
    else if (int'(cpu_bus.bank) < FAST_BANKS)
      region = REG_FAST;
    else
      region = REG_NONE;
  end

  // request side, each target only sees a strobe for its own region
  assign fast_en    = cpu_req && (region == REG_FAST);
  assign fast_we    = cpu_bus.we;
  assign fast_addr  = {cpu_bus.bank[FAST_BANK_BITS-1:0], cpu_bus.addr};
  assign fast_wdata = cpu_bus.wdata;

  assign slot_sel   = cpu_req && (region == REG_SLOT);
  assign slot_we    = cpu_bus.we;
  assign slot_idx   = cpu_bus.addr[3:0];
  assign slot_wdata = cpu_bus.wdata;

  assign slow_req       = cpu_req && (region == REG_SLOW);
  assign slow_bus.addr  = {cpu_bus.bank[0], cpu_bus.addr};
  assign slow_bus.wdata = cpu_bus.wdata;
  assign slow_bus.we    = cpu_bus.we;

  // hold the region until the access completes
  // fast, slot and unmapped finish next cycle, slow waits for slow_done
  always_ff @(posedge clk_sys)
  begin
    if (rst)
    begin
      busy     <= 1'b0;
      region_q <= REG_NONE;
    end
    else if (cpu_req)
    begin
      busy     <= 1'b1;
      region_q <= region;
    end
    else if (rsp_valid)
      busy <= 1'b0;
  end

  assign rsp_valid = busy && ((region_q != REG_SLOW) || slow_done);

  // return path mux, unmapped reads see the floating bus value
  always_comb
  begin
    case (region_q)
      REG_FAST: rsp.rdata = fast_rdata;
      REG_SLOW: rsp.rdata = slow_rdata;
      REG_SLOT: rsp.rdata = slot_rdata;
      default:  rsp.rdata = UNMAPPED_DATA;
    endcase
  end

endmodule

/* verilog/slot_regs.sv */
`timescale 1ns/10ps

module slot_regs (
  input  logic       clk_sys,
  input  logic       rst,
  input  logic       sel,
  input  logic       we,
  input  logic [3:0] idx,
  input  logic [7:0] wdata,
  output logic [7:0] rdata
);

  // sixteen device registers at $C0F0..$C0FF
  logic [7:0] regs [16];

  // the card comes out of reset with every register cleared
  always_ff @(posedge clk_sys)
  begin
    if (rst)
    begin
      for (int i = 0; i < 16; i++)
        regs[i] <= 8'h00;
    end
    else if (sel && we)
      regs[idx] <= wdata;
  end

  // read data is ready the cycle after the device select
  always_ff @(posedge clk_sys)
  begin
    if (sel)
      rdata <= regs[idx];
  end

endmodule

/* verilog/mem_bank.sv */
`timescale 1ns/10ps

module mem_bank #(
  parameter int ADDR_BITS = 17
) (
  input  logic                 clk_sys,
  input  logic                 en,
  input  logic                 we,
  input  logic [ADDR_BITS-1:0] addr,
  input  logic [7:0]           wdata,
  output logic [7:0]           rdata
);

  // plain byte array, maps onto block RAM
  logic [7:0] mem [2**ADDR_BITS];

  // read data shows the old contents on a write cycle (read first)
  always_ff @(posedge clk_sys)
  begin
    if (en)
    begin
      if (we)
        mem[addr] <= wdata;
      rdata <= mem[addr];
    end
  end

endmodule

/* verilog/iigs_mem_pkg.sv */
package iigs_mem_pkg;

  // one CPU access as it leaves the 65816 side of the bus
  typedef struct packed {
    logic [7:0]  bank;
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        we;
  } bus_req_t;

  // read data returned with rsp_valid, meaningless for a write
  typedef struct packed {
    logic [7:0] rdata;
  } bus_rsp_t;

  // slow RAM byte access, the address is {bank[0], addr}
  typedef struct packed {
    logic [16:0] addr;
    logic [7:0]  wdata;
    logic        we;
  } ram_req_t;

  // one display byte together with the slow RAM address it came from
  typedef struct packed {
    logic [16:0] addr;
    logic [7:0]  data;
  } vid_byte_t;

  typedef enum logic [1:0] {
    REG_FAST,
    REG_SLOW,
    REG_SLOT,
    REG_NONE
  } region_e;

  // slot 7 device select window
  localparam logic [15:0] SLOT_BASE = 16'hC0F0;
  localparam logic [15:0] SLOT_LAST = 16'hC0FF;

  // shadowed display pages and the start of the I/O space
  localparam logic [15:0] TEXT_LO = 16'h0400;
  localparam logic [15:0] TEXT_HI = 16'h07FF;
  localparam logic [15:0] HGR1_LO = 16'h2000;
  localparam logic [15:0] HGR1_HI = 16'h3FFF;
  localparam logic [15:0] HGR2_LO = 16'h4000;
  localparam logic [15:0] HGR2_HI = 16'h5FFF;
  localparam logic [15:0] IO_LO   = 16'hC000;

  // floating bus value seen on an access that hits nothing
  localparam logic [7:0] UNMAPPED_DATA = 8'h80;

endpackage
